// ==== common/spi_regmap_pkg.sv ====
package spi_regmap_pkg;

	//////////////////////////////////////////////////
	// bus widths
	//////////////////////////////////////////////////

	// avalon word address
	localparam int ADDR_W = 8;
	// register width unless the top overrides it
	localparam int DATA_W_DEFAULT = 32;

	// register map, word addresses
	typedef enum logic [ADDR_W-1:0] {
		ADDR_CONTROL    = 8'h00,
		ADDR_STATUS     = 8'h01,
		ADDR_DATA_WRITE = 8'h02,
		ADDR_DATA_READ  = 8'h03
	} reg_addr_e;

	//////////////////////////////////////////////////
	// control register bits
	//////////////////////////////////////////////////

	// start a write transfer, cleared when taken
	localparam int CTL_CMD_WRITE = 0;
	// start a read transfer, cleared when taken
	localparam int CTL_CMD_READ = 1;
	// self clearing, drops both irq flags
	localparam int CTL_IRQ_RESET = 2;
	localparam int CTL_IRQ_WR_EN = 3;
	localparam int CTL_IRQ_RD_EN = 4;

	//////////////////////////////////////////////////
	// status register bits
	//////////////////////////////////////////////////

	// busy code sits at the bottom
	localparam int STS_BUSY_LO = 0;
	localparam int STS_BUSY_W = 2;
	// bit 2 unused
	localparam int STS_IRQ_WR = 3;
	localparam int STS_IRQ_RD = 4;

endpackage

// ==== common/spi_xfer_pkg.sv ====
package spi_xfer_pkg;

	// sequencer states
	// start states last one cycle, end states wait for the engine
	typedef enum logic [2:0] {
		XFER_IDLE      = 3'd0,
		XFER_WRITE     = 3'd1,
		XFER_READ      = 3'd2,
		XFER_WRITE_END = 3'd3,
		XFER_READ_END  = 3'd4
	} xfer_state_e;

	// busy code as seen in status bits 1:0
	// 3 is never produced
	typedef enum logic [1:0] {
		STATUS_IDLE    = 2'd0,
		STATUS_WRITING = 2'd1,
		STATUS_READING = 2'd2
	} xfer_status_e;

endpackage

// ==== src/avalon_bus_port.sv ====
module avalon_bus_port (
	input  logic clk,
	input  logic reset_n,
	input  logic chip_select,
	input  logic read,
	input  logic write,
	output logic wait_request,
	output logic reg_write,
	output logic reg_read
);

	// combined request and its history
	logic req;
	logic req_d1;
	logic req_d2;
	// per kind history for the strobes
	logic wr_d1;
	logic wr_d2;
	logic rd_d1;
	logic rd_d2;

	assign req = write | read;

	//////////////////////////////////////////////////
	// wait_request
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			req_d1 <= 1'b0;
			req_d2 <= 1'b0;
		end
		else
		begin
			req_d1 <= req;
			req_d2 <= req_d1;
		end
	end

	// held off until the request has been seen on two edges
	assign wait_request = req & ~req_d2;

	//////////////////////////////////////////////////
	// access strobes
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			wr_d1 <= 1'b0;
			wr_d2 <= 1'b0;
			rd_d1 <= 1'b0;
			rd_d2 <= 1'b0;
		end
		else
		begin
			wr_d1 <= write;
			wr_d2 <= wr_d1;
			rd_d1 <= read;
			rd_d2 <= rd_d1;
		end
	end

	// rising edge after first sample, one cycle wide
	// only for this slave
	assign reg_write = wr_d1 & ~wr_d2 & chip_select;
	assign reg_read  = rd_d1 & ~rd_d2 & chip_select;

endmodule

// ==== csr/csr_bank.sv ====
module csr_bank #(
	parameter int DATA_W = spi_regmap_pkg::DATA_W_DEFAULT
) (
	input  logic                            clk,
	input  logic                            reset_n,
	input  logic [spi_regmap_pkg::ADDR_W-1:0] address,
	input  logic [DATA_W-1:0]               write_data,
	input  logic                            reg_write,
	input  logic                            reg_read,
	input  logic                            write_taken,
	input  logic                            read_taken,
	input  logic                            write_done,
	input  logic                            read_done,
	input  spi_xfer_pkg::xfer_status_e      xfer_status,
	input  logic [DATA_W-1:0]               data_read_from_spi,
	output logic [DATA_W-1:0]               read_data,
	output logic                            cmd_write,
	output logic                            cmd_read,
	output logic [DATA_W-1:0]               data_write_to_spi,
	output logic                            irq
);

	import spi_regmap_pkg::*;

	// stored control bits
	logic irq_wr_en;
	logic irq_rd_en;
	// decoded writes
	logic ctrl_wr;
	logic dwr_wr;
	logic irq_reset;
	// data registers
	logic [DATA_W-1:0] data_write_q;
	logic [DATA_W-1:0] data_read_q;
	// interrupt flags
	logic irq_wr_flag;
	logic irq_rd_flag;
	// readback words
	logic [DATA_W-1:0] ctrl_word;
	logic [DATA_W-1:0] status_word;
	logic [DATA_W-1:0] rd_mux;

	//////////////////////////////////////////////////
	// write decode
	//////////////////////////////////////////////////

	always_comb
	begin
		ctrl_wr = 1'b0;
		dwr_wr  = 1'b0;
		if (reg_write)
		begin
			case (reg_addr_e'(address))
				ADDR_CONTROL:    ctrl_wr = 1'b1;
				ADDR_DATA_WRITE: dwr_wr = 1'b1;
				// status and data-read ignore writes
				default: ;
			endcase
		end
	end

	// not stored, acts on the write itself
	assign irq_reset = ctrl_wr & write_data[CTL_IRQ_RESET];

	// control register
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			cmd_write <= 1'b0;
			cmd_read  <= 1'b0;
			irq_wr_en <= 1'b0;
			irq_rd_en <= 1'b0;
		end
		else
		begin
			// sequencer took the command
			if (write_taken)
				cmd_write <= 1'b0;
			if (read_taken)
				cmd_read <= 1'b0;
			// a fresh bus write wins over the clear
			if (ctrl_wr)
			begin
				cmd_write <= write_data[CTL_CMD_WRITE];
				cmd_read  <= write_data[CTL_CMD_READ];
				irq_wr_en <= write_data[CTL_IRQ_WR_EN];
				irq_rd_en <= write_data[CTL_IRQ_RD_EN];
			end
		end
	end

	// data-write and captured read word
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			data_write_q <= '0;
			data_read_q  <= '0;
		end
		else
		begin
			if (dwr_wr)
				data_write_q <= write_data;
			// engine word is valid from the fall on
			if (read_done)
				data_read_q <= data_read_from_spi;
		end
	end

	assign data_write_to_spi = data_write_q;

	//////////////////////////////////////////////////
	// interrupts
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			irq_wr_flag <= 1'b0;
			irq_rd_flag <= 1'b0;
			irq         <= 1'b0;
		end
		else
		begin
			if (irq_reset)
			begin
				irq_wr_flag <= 1'b0;
				irq_rd_flag <= 1'b0;
			end
			// a done in the same cycle still lands
			if (write_done && irq_wr_en)
				irq_wr_flag <= 1'b1;
			if (read_done && irq_rd_en)
				irq_rd_flag <= 1'b1;
			irq <= irq_wr_flag | irq_rd_flag;
		end
	end

	//////////////////////////////////////////////////
	// readback
	//////////////////////////////////////////////////

	always_comb
	begin
		ctrl_word = '0;
		ctrl_word[CTL_CMD_WRITE] = cmd_write;
		ctrl_word[CTL_CMD_READ]  = cmd_read;
		ctrl_word[CTL_IRQ_WR_EN] = irq_wr_en;
		ctrl_word[CTL_IRQ_RD_EN] = irq_rd_en;

		status_word = '0;
		status_word[STS_BUSY_LO +: STS_BUSY_W] = xfer_status;
		status_word[STS_IRQ_WR] = irq_wr_flag;
		status_word[STS_IRQ_RD] = irq_rd_flag;

		case (reg_addr_e'(address))
			ADDR_CONTROL:    rd_mux = ctrl_word;
			ADDR_STATUS:     rd_mux = status_word;
			ADDR_DATA_WRITE: rd_mux = data_write_q;
			ADDR_DATA_READ:  rd_mux = data_read_q;
			default:         rd_mux = '0;
		endcase
	end

	// valid when wait_request drops
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			read_data <= '0;
		else if (reg_read)
			read_data <= rd_mux;
	end

endmodule

// ==== xfer/transfer_sequencer.sv ====
module transfer_sequencer (
	input  logic                       clk,
	input  logic                       reset_n,
	input  logic                       cmd_write,
	input  logic                       cmd_read,
	input  logic                       data_pack_ready,
	output logic                       go_transfer,
	output logic                       write_taken,
	output logic                       read_taken,
	output logic                       write_done,
	output logic                       read_done,
	output spi_xfer_pkg::xfer_status_e xfer_status
);

	import spi_xfer_pkg::*;

	xfer_state_e state;
	xfer_state_e state_next;
	logic        idle;
	// engine handshake sync
	logic        dpr_d1;
	logic        dpr_d2;
	logic        dpr_fall;

	//////////////////////////////////////////////////
	// command acceptance
	//////////////////////////////////////////////////

	assign idle = (state == XFER_IDLE);

	// one cycle, on the way out of idle
	// write has priority when both are pending
	assign write_taken = idle & cmd_write;
	assign read_taken  = idle & cmd_read & ~cmd_write;
	assign go_transfer = write_taken | read_taken;

	//////////////////////////////////////////////////
	// done detection
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			dpr_d1 <= 1'b0;
			dpr_d2 <= 1'b0;
		end
		else
		begin
			dpr_d1 <= data_pack_ready;
			dpr_d2 <= dpr_d1;
		end
	end

	// high then low on consecutive samples
	assign dpr_fall = dpr_d2 & ~dpr_d1;

	// steer by transfer kind
	assign write_done = dpr_fall & (state == XFER_WRITE_END);
	assign read_done  = dpr_fall & (state == XFER_READ_END);

	//////////////////////////////////////////////////
	// state machine
	//////////////////////////////////////////////////

	always_comb
	begin
		state_next = state;
		case (state)
			XFER_IDLE:
			begin
				if (write_taken)
					state_next = XFER_WRITE;
				else if (read_taken)
					state_next = XFER_READ;
			end
			XFER_WRITE:     state_next = XFER_WRITE_END;
			XFER_READ:      state_next = XFER_READ_END;
			// wait for the engine to finish
			XFER_WRITE_END:
			begin
				if (write_done)
					state_next = XFER_IDLE;
			end
			XFER_READ_END:
			begin
				if (read_done)
					state_next = XFER_IDLE;
			end
			default:        state_next = XFER_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			state <= XFER_IDLE;
		else
			state <= state_next;
	end

	// busy code for the status register
	always_comb
	begin
		case (state)
			XFER_WRITE, XFER_WRITE_END: xfer_status = STATUS_WRITING;
			XFER_READ, XFER_READ_END:   xfer_status = STATUS_READING;
			default:                    xfer_status = STATUS_IDLE;
		endcase
	end

endmodule

// ==== src/spi_ctrl_top.sv ====
module spi_ctrl_top #(
	parameter int DATA_W = spi_regmap_pkg::DATA_W_DEFAULT
) (
	input  logic                              clk,
	input  logic                              reset_n,
	input  logic                              chip_select,
	input  logic [spi_regmap_pkg::ADDR_W-1:0] address,
	input  logic                              read,
	input  logic                              write,
	input  logic [DATA_W-1:0]                 write_data,
	input  logic                              data_pack_ready,
	input  logic [DATA_W-1:0]                 data_read_from_spi,
	output logic                              wait_request,
	output logic [DATA_W-1:0]                 read_data,
	output logic                              go_transfer,
	output logic [DATA_W-1:0]                 data_write_to_spi,
	output logic                              irq
);

	import spi_xfer_pkg::*;

	// bus port to registers
	logic reg_write;
	logic reg_read;
	// registers to sequencer
	logic cmd_write;
	logic cmd_read;
	// sequencer back to registers
	logic         write_taken;
	logic         read_taken;
	logic         write_done;
	logic         read_done;
	xfer_status_e xfer_status;

	avalon_bus_port i_bus_port (
		.clk          (clk),
		.reset_n      (reset_n),
		.chip_select  (chip_select),
		.read         (read),
		.write        (write),
		.wait_request (wait_request),
		.reg_write    (reg_write),
		.reg_read     (reg_read)
	);

	csr_bank #(
		.DATA_W (DATA_W)
	) i_csr_bank (
		.clk                (clk),
		.reset_n            (reset_n),
		.address            (address),
		.write_data         (write_data),
		.reg_write          (reg_write),
		.reg_read           (reg_read),
		.write_taken        (write_taken),
		.read_taken         (read_taken),
		.write_done         (write_done),
		.read_done          (read_done),
		.xfer_status        (xfer_status),
		.data_read_from_spi (data_read_from_spi),
		.read_data          (read_data),
		.cmd_write          (cmd_write),
		.cmd_read           (cmd_read),
		.data_write_to_spi  (data_write_to_spi),
		.irq                (irq)
	);

	// one transfer in flight at a time
	transfer_sequencer i_sequencer (
		.clk             (clk),
		.reset_n         (reset_n),
		.cmd_write       (cmd_write),
		.cmd_read        (cmd_read),
		.data_pack_ready (data_pack_ready),
		.go_transfer     (go_transfer),
		.write_taken     (write_taken),
		.read_taken      (read_taken),
		.write_done      (write_done),
		.read_done       (read_done),
		.xfer_status     (xfer_status)
	);

endmodule

// ==== dv/spi_ctrl_tb.sv ====
module spi_ctrl_tb;

	import spi_regmap_pkg::*;
	import spi_xfer_pkg::*;

	localparam int DATA_W = 32;
	localparam int PERIOD = 40;
	// run budget from the worst transfer of 1 + 20 + 3 cycles plus slack
	localparam int NUM_XFERS = 5;
	localparam int XFER_CYCLES = 26;
	localparam int NUM_ACCESS = 48;
	localparam int ACCESS_CYCLES = 8;
	localparam int TIMEOUT =
		2 * (NUM_XFERS * XFER_CYCLES + NUM_ACCESS * ACCESS_CYCLES + 10) * PERIOD;

	logic              clk;
	logic              reset_n;
	logic              chip_select;
	logic [ADDR_W-1:0] address;
	logic              read;
	logic              write;
	logic [DATA_W-1:0] write_data;
	logic              data_pack_ready;
	logic [DATA_W-1:0] data_read_from_spi;
	logic              wait_request;
	logic [DATA_W-1:0] read_data;
	logic              go_transfer;
	logic [DATA_W-1:0] data_write_to_spi;
	logic              irq;

	// register model
	logic              m_cmd_write;
	logic              m_cmd_read;
	logic              m_wr_en;
	logic              m_rd_en;
	logic              m_flag_wr;
	logic              m_flag_rd;
	logic [DATA_W-1:0] m_data_write;
	logic [DATA_W-1:0] m_data_read;
	xfer_status_e      m_phase;

	// engine model bookkeeping
	int                go_count;
	int                done_count;
	int                hold_lo;
	logic [DATA_W-1:0] last_go_data;
	time               go_times[$];
	time               fall_times[$];

	// reads waiting for the compare process
	string             chk_name[$];
	logic [DATA_W-1:0] chk_exp[$];
	logic [DATA_W-1:0] chk_act[$];
	int                pushed;
	int                checked;
	int                error_count;
	string             test_name;

	spi_ctrl_top #(
		.DATA_W (DATA_W)
	) i_dut (
		.clk                (clk),
		.reset_n            (reset_n),
		.chip_select        (chip_select),
		.address            (address),
		.read               (read),
		.write              (write),
		.write_data         (write_data),
		.data_pack_ready    (data_pack_ready),
		.data_read_from_spi (data_read_from_spi),
		.wait_request       (wait_request),
		.read_data          (read_data),
		.go_transfer        (go_transfer),
		.data_write_to_spi  (data_write_to_spi),
		.irq                (irq)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////
	// error handling
	//////////////////////////////////////////////////

	task automatic fail_run();
		$display("TEST FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [DATA_W-1:0] exp,
		input logic [DATA_W-1:0] act);
		error_count++;
		$display("ERROR %s: expected %h actual %h", name, exp, act);
		fail_run();
	endtask

	task automatic report_problem(input string what);
		error_count++;
		$display("ERROR: %s", what);
		fail_run();
	endtask

	task automatic check_value(input string name, input logic [DATA_W-1:0] exp,
		input logic [DATA_W-1:0] act);
		assert (act === exp)
		else
			report_mismatch(name, exp, act);
	endtask

	//////////////////////////////////////////////////
	// register model
	//////////////////////////////////////////////////

	// expected register word as the bus should see it
	function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] addr);
		logic [DATA_W-1:0] word;
		word = '0;
		case (addr)
			ADDR_CONTROL:
			begin
				word[CTL_CMD_WRITE] = m_cmd_write;
				word[CTL_CMD_READ]  = m_cmd_read;
				word[CTL_IRQ_WR_EN] = m_wr_en;
				word[CTL_IRQ_RD_EN] = m_rd_en;
			end
			ADDR_STATUS:
			begin
				word[STS_BUSY_LO +: STS_BUSY_W] = m_phase;
				word[STS_IRQ_WR] = m_flag_wr;
				word[STS_IRQ_RD] = m_flag_rd;
			end
			ADDR_DATA_WRITE: word = m_data_write;
			ADDR_DATA_READ:  word = m_data_read;
			default:         word = '0;
		endcase
		return word;
	endfunction

	// status and data-read ignore writes
	task automatic apply_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		if (addr == ADDR_CONTROL)
		begin
			m_cmd_write = data[CTL_CMD_WRITE];
			m_cmd_read  = data[CTL_CMD_READ];
			m_wr_en     = data[CTL_IRQ_WR_EN];
			m_rd_en     = data[CTL_IRQ_RD_EN];
			// irq reset is not stored
			if (data[CTL_IRQ_RESET])
			begin
				m_flag_wr = 1'b0;
				m_flag_rd = 1'b0;
			end
		end
		else if (addr == ADDR_DATA_WRITE)
			m_data_write = data;
	endtask

	//////////////////////////////////////////////////
	// avalon master
	//////////////////////////////////////////////////

	task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		int wait_cnt;
		wait_cnt = 0;
		@(posedge clk);
		#5;
		chip_select = 1'b1;
		address     = addr;
		write_data  = data;
		write       = 1'b1;
		@(negedge clk);
		while (wait_request)
		begin
			wait_cnt++;
			// the dut takes the word at the end of the second wait cycle
			if (wait_cnt == 2)
				apply_write(addr, data);
			@(negedge clk);
		end
		check_value({test_name, " write wait cycles"}, 2, wait_cnt);
		@(posedge clk);
		#5;
		chip_select = 1'b0;
		write       = 1'b0;
		repeat (2) @(posedge clk);
	endtask

	task automatic bus_read(input logic [ADDR_W-1:0] addr);
		int                wait_cnt;
		logic [DATA_W-1:0] exp;
		wait_cnt = 0;
		exp      = '0;
		@(posedge clk);
		#5;
		chip_select = 1'b1;
		address     = addr;
		read        = 1'b1;
		@(negedge clk);
		while (wait_request)
		begin
			wait_cnt++;
			// the last pass is the strobe cycle that gets latched
			exp = expected_read(addr);
			@(negedge clk);
		end
		check_value({test_name, " read wait cycles"}, 2, wait_cnt);
		chk_name.push_back($sformatf("%s addr %0d", test_name, addr));
		chk_exp.push_back(exp);
		chk_act.push_back(read_data);
		pushed++;
		@(posedge clk);
		#5;
		chip_select = 1'b0;
		read        = 1'b0;
		repeat (2) @(posedge clk);
	endtask

	// let done, flag and irq settle
	task automatic wait_transfers(input int n);
		wait (done_count == n);
		repeat (2) @(negedge clk);
	endtask

	//////////////////////////////////////////////////
	// spi engine model
	//////////////////////////////////////////////////

	// counts every go_transfer pulse on its own
	initial
	begin
		forever
		begin
			@(negedge clk);
			if (go_transfer)
			begin
				go_count++;
				go_times.push_back($time);
			end
		end
	end

	initial
	begin
		int   hold;
		logic is_write;
		forever
		begin
			@(negedge clk);
			if (go_transfer)
			begin
				last_go_data = data_write_to_spi;
				// write wins when both are pending
				is_write = m_cmd_write;
				@(posedge clk);
				#1;
				if (is_write)
				begin
					m_cmd_write = 1'b0;
					m_phase     = STATUS_WRITING;
				end
				else
				begin
					m_cmd_read = 1'b0;
					m_phase    = STATUS_READING;
				end
				#4;
				data_pack_ready = 1'b1;
				hold = hold_lo + $urandom % (21 - hold_lo);
				repeat (hold)
				begin
					@(negedge clk);
					assert (!go_transfer)
					else
						report_problem("go_transfer pulsed while a transfer was in flight");
					@(posedge clk);
				end
				#5;
				data_pack_ready    = 1'b0;
				data_read_from_spi = $urandom;
				fall_times.push_back($time);
				// two sync flops then the done pulse
				repeat (2) @(posedge clk);
				#1;
				m_phase = STATUS_IDLE;
				if (is_write)
				begin
					if (m_wr_en)
						m_flag_wr = 1'b1;
				end
				else
				begin
					m_data_read = data_read_from_spi;
					if (m_rd_en)
						m_flag_rd = 1'b1;
				end
				done_count++;
			end
		end
	end

	//////////////////////////////////////////////////
	// compare and watchdog
	//////////////////////////////////////////////////

	initial
	begin
		string             name;
		logic [DATA_W-1:0] exp;
		logic [DATA_W-1:0] act;
		forever
		begin
			wait (pushed > checked);
			name = chk_name.pop_front();
			exp  = chk_exp.pop_front();
			act  = chk_act.pop_front();
			assert (act === exp)
			else
				report_mismatch(name, exp, act);
			checked++;
		end
	end

	initial
	begin
		#(TIMEOUT);
		$display("watchdog: run did not finish within %0d time units", TIMEOUT);
		fail_run();
	end

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////

	initial
	begin
		logic [DATA_W-1:0] word;
		int                go_before;
		int                i;
		void'($urandom(32'h3a69));
		reset_n = 1'b0;
		chip_select = 1'b0;
		address = '0;
		read = 1'b0;
		write = 1'b0;
		write_data = '0;
		data_pack_ready = 1'b0;
		data_read_from_spi = '0;
		{m_cmd_write, m_cmd_read, m_wr_en, m_rd_en, m_flag_wr, m_flag_rd} = '0;
		m_data_write = '0;
		m_data_read = '0;
		m_phase = STATUS_IDLE;
		hold_lo = 3;
		repeat (3) @(posedge clk);
		#5;
		reset_n = 1'b1;

		// reset values
		test_name = "reset";
		@(negedge clk);
		check_value("reset wait_request", 0, wait_request);
		check_value("reset go_transfer", 0, go_transfer);
		check_value("reset irq", 0, irq);
		for (i = 0; i < 4; i++)
			bus_read(i);

		// plain readback and writes to read-only registers
		test_name = "readback";
		for (i = 0; i < 4; i++)
		begin
			word = $urandom;
			bus_write(ADDR_DATA_WRITE, word);
			bus_read(ADDR_DATA_WRITE);
		end
		bus_write(ADDR_CONTROL, (1 << CTL_IRQ_WR_EN) | (1 << CTL_IRQ_RD_EN));
		bus_read(ADDR_CONTROL);
		bus_write(ADDR_STATUS, $urandom);
		bus_write(ADDR_DATA_READ, $urandom);
		bus_read(ADDR_STATUS);
		bus_read(ADDR_DATA_READ);

		// write transfer with write-done irq
		test_name = "write xfer";
		word = $urandom;
		bus_write(ADDR_DATA_WRITE, word);
		go_before = go_count;
		bus_write(ADDR_CONTROL, (1 << CTL_CMD_WRITE) | (1 << CTL_IRQ_WR_EN));
		wait (data_pack_ready);
		bus_read(ADDR_STATUS);
		wait_transfers(1);
		check_value("write xfer go count", 1, go_count - go_before);
		check_value("write xfer spi word", word, last_go_data);
		check_value("write xfer irq", m_flag_wr | m_flag_rd, irq);
		bus_read(ADDR_STATUS);
		bus_read(ADDR_CONTROL);

		// interrupt reset
		test_name = "irq reset";
		bus_write(ADDR_CONTROL, 1 << CTL_IRQ_RESET);
		@(negedge clk);
		check_value("irq reset irq", 0, irq);
		bus_read(ADDR_STATUS);

		// read transfers with enables off then read-done on
		test_name = "read xfer";
		bus_write(ADDR_CONTROL, 1 << CTL_CMD_READ);
		wait_transfers(2);
		check_value("read xfer irq off", 0, irq);
		bus_read(ADDR_DATA_READ);
		bus_read(ADDR_STATUS);
		bus_write(ADDR_CONTROL, (1 << CTL_CMD_READ) | (1 << CTL_IRQ_RD_EN));
		wait_transfers(3);
		check_value("read xfer irq on", m_flag_wr | m_flag_rd, irq);
		bus_read(ADDR_DATA_READ);
		bus_read(ADDR_STATUS);
		test_name = "irq reset 2";
		bus_write(ADDR_CONTROL, 1 << CTL_IRQ_RESET);
		@(negedge clk);
		check_value("irq reset 2 irq", 0, irq);

		// read command queued behind a busy write
		test_name = "pending read";
		hold_lo = 15;
		word = $urandom;
		bus_write(ADDR_DATA_WRITE, word);
		go_before = go_count;
		bus_write(ADDR_CONTROL,
			(1 << CTL_CMD_WRITE) | (1 << CTL_IRQ_WR_EN) | (1 << CTL_IRQ_RD_EN));
		wait (data_pack_ready);
		bus_write(ADDR_CONTROL,
			(1 << CTL_CMD_READ) | (1 << CTL_IRQ_WR_EN) | (1 << CTL_IRQ_RD_EN));
		bus_read(ADDR_CONTROL);
		bus_read(ADDR_STATUS);
		wait_transfers(5);
		check_value("pending read go count", 2, go_count - go_before);
		check_value("pending read irq", m_flag_wr | m_flag_rd, irq);
		bus_read(ADDR_DATA_READ);
		bus_read(ADDR_STATUS);
		// one go per finished transfer
		check_value("total go count", fall_times.size(), go_times.size());
		// each go after the previous fall
		for (i = 1; i < go_times.size(); i++)
		begin
			assert (go_times[i] > fall_times[i-1])
			else
				report_problem("a go_transfer came before the previous transfer finished");
		end

		wait (checked == pushed);
		if (error_count == 0)
		begin
			$display("TEST PASS");
			$finish;
		end
		else
			fail_run();
	end

endmodule

// ==== flist.f ====
common/spi_regmap_pkg.sv
common/spi_xfer_pkg.sv
src/avalon_bus_port.sv
csr/csr_bank.sv
xfer/transfer_sequencer.sv
src/spi_ctrl_top.sv
dv/spi_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: spi_ctrl

sources:
  - common/spi_regmap_pkg.sv
  - common/spi_xfer_pkg.sv
  - src/avalon_bus_port.sv
  - csr/csr_bank.sv
  - xfer/transfer_sequencer.sv
  - src/spi_ctrl_top.sv
  - target: simulation
    files:
      - dv/spi_ctrl_tb.sv
